/* verilog/gps_board_defs.svh */
`ifndef GPS_BOARD_DEFS_SVH
`define GPS_BOARD_DEFS_SVH

// Channel status word widths
`define ACC_TRACK_W        18 // Prompt width and shown accumulator slice
`define ACC_W              20 // Full accumulator
`define CODE_SHIFT_W       15
`define FEED_COUNT_W       9  // Feed words and packet counters
`define TRACK_COUNT_W      4
`define SAMPLE_W           3  // Sample and carrier values

// Board display resources
`define SW_W               18
`define LEDR_W             18
`define LEDG_W             9
`define SEG_W              7
`define NUM_DIGITS         8

// Switch positions
`define SW_ACC             17 // Accumulator instead of prompt
`define SW_QSEL            16 // Q instead of I
`define SW_CS              15 // Code shift on the digits
`define SW_WORDS           14
`define SW_TRACK           13
`define SW_PKT             12
`define SW_PKT_GOOD        11
`define SW_CARRIER_Q       10

// Divider and stretcher timing
`define SAMPLE_DIV_RELOAD  8  // Toggle every 9 cycles
`define SAMPLE_DIV_W       4
`define READY_HOLD         7  // Flag held 8 cycles
`define READY_HOLD_W       3

`endif

/* verilog/gps_board_pkg.sv */
`include "gps_board_defs.svh"

package gps_board_pkg;

   // Source of the red LED word, in switch priority order
   typedef enum logic [2:0] {
      DISP_FEED_WORDS,
      DISP_TRACK_COUNT,
      DISP_PKT_ALL,
      DISP_PKT_GOOD,
      DISP_IQ
   } disp_src_e;

   typedef logic [3:0] nibble_t;

   typedef logic [`SEG_W-1:0] seg7_t; // Active low, bit 0 is segment a

   typedef logic [`ACC_TRACK_W-1:0] iq_word_t;

   typedef logic [`ACC_W-1:0] acc_word_t;

   typedef logic [`CODE_SHIFT_W-1:0] code_shift_t;

   typedef logic [`FEED_COUNT_W-1:0] feed_count_t;

   typedef logic [`LEDR_W-1:0] ledr_t;

   typedef logic [`LEDG_W-1:0] ledg_t;

endpackage

/* verilog/sample_clock_gen.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module sample_clock_gen (
   input  logic clk_16_8,
   input  logic reset_i,
   output logic sample_clk_o
);

   logic [`SAMPLE_DIV_W-1:0] div_count;
   logic                     div_zero;

   assign div_zero = (div_count == '0);

   // Down-counter with reload, the level flips on every wrap
   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         div_count    <= `SAMPLE_DIV_W'(`SAMPLE_DIV_RELOAD);
         sample_clk_o <= 1'b0;
      end else begin
         if (div_zero) begin
            div_count <= `SAMPLE_DIV_W'(`SAMPLE_DIV_RELOAD); // Wrap
         end else begin
            div_count <= div_count - 1'b1;
         end
         if (div_zero) begin
            sample_clk_o <= ~sample_clk_o; // Half period done
         end
      end
   end

endmodule

/* verilog/ready_stretcher.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module ready_stretcher (
   input  logic clk_16_8,
   input  logic reset_i,
   input  logic tracking_ready_i,
   output logic ready_flag_o
);

   logic [`READY_HOLD_W-1:0] hold_count;

   // Pulse loads the hold time; flag drops once the count is used up
   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         hold_count   <= '0;
         ready_flag_o <= 1'b0;
      end else if (tracking_ready_i) begin
         hold_count   <= `READY_HOLD_W'(`READY_HOLD); // Restart hold
         ready_flag_o <= 1'b1;
      end else if (hold_count == '0) begin
         ready_flag_o <= 1'b0; // Hold expired
      end else begin
         hold_count   <= hold_count - 1'b1;
      end
   end

endmodule

/* verilog/status_display_mux.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module status_display_mux
   import gps_board_pkg::*;
(
   input  logic                      clk_16_8,
   input  logic                      reset_i,
   input  logic [`SW_W-1:0]          sw_i,
   input  logic                      ready_flag_i,
   input  iq_word_t                  i_prompt_i,
   input  iq_word_t                  q_prompt_i,
   input  acc_word_t                 acc_i_i,
   input  acc_word_t                 acc_q_i,
   input  code_shift_t               code_shift_i,
   input  feed_count_t               words_avail_i,
   input  feed_count_t               pkt_count_i,
   input  feed_count_t               good_pkt_count_i,
   input  logic [`TRACK_COUNT_W-1:0] track_count_i,
   input  logic [`SAMPLE_W-1:0]      carrier_i_i,
   input  logic [`SAMPLE_W-1:0]      carrier_q_i,
   input  logic [`SAMPLE_W-1:0]      sample_data_i,
   input  logic                      sample_valid_i,
   input  logic                      link_status_i,
   output ledr_t                     ledr_o,
   output ledg_t                     ledg_o,
   output nibble_t [`NUM_DIGITS-1:0] digit_nibble_o,
   output logic [`NUM_DIGITS-1:0]    digit_on_o
);

   iq_word_t                  value_word;
   disp_src_e                 ledr_src;
   ledr_t                     ledr_next;
   ledg_t                     ledg_next;
   logic [`SAMPLE_W-1:0]      carrier_sel;
   nibble_t [`NUM_DIGITS-1:0] nibble_next;
   logic [`NUM_DIGITS-1:0]    on_next;

   // Value word from accumulators or prompts
   always_comb begin
      if (sw_i[`SW_ACC]) begin
         value_word = sw_i[`SW_QSEL] ? acc_q_i[`ACC_TRACK_W-1:0] : acc_i_i[`ACC_TRACK_W-1:0];
      end else begin
         value_word = sw_i[`SW_QSEL] ? q_prompt_i : i_prompt_i;
      end
   end

   always_comb begin
      if (sw_i[`SW_WORDS]) begin
         ledr_src = DISP_FEED_WORDS;
      end else if (sw_i[`SW_TRACK]) begin
         ledr_src = DISP_TRACK_COUNT;
      end else if (sw_i[`SW_PKT]) begin
         ledr_src = sw_i[`SW_PKT_GOOD] ? DISP_PKT_GOOD : DISP_PKT_ALL;
      end else begin
         ledr_src = DISP_IQ;
      end
   end

   always_comb begin
      ledr_next = ledr_t'(value_word);
      case (ledr_src)
         DISP_FEED_WORDS:  ledr_next = ledr_t'(words_avail_i);   // Zero-extended
         DISP_TRACK_COUNT: ledr_next = ledr_t'(track_count_i);
         DISP_PKT_ALL:     ledr_next = ledr_t'(pkt_count_i);
         DISP_PKT_GOOD:    ledr_next = ledr_t'(good_pkt_count_i);
         DISP_IQ:          ledr_next = ledr_t'(value_word);
      endcase
   end

   assign carrier_sel = sw_i[`SW_CARRIER_Q] ? carrier_q_i : carrier_i_i;

   assign ledg_next = {link_status_i, carrier_sel, sample_data_i, sample_valid_i, ready_flag_i};

   // Digits 7..5 stay blank and digit 4 carries the top bits of the value word
   always_comb begin
      nibble_next    = '0;
      on_next        = 8'h1f;
      nibble_next[4] = {2'b00, value_word[17:16]};
      if (sw_i[`SW_CS]) begin
         on_next[4]     = 1'b0;
         nibble_next[3] = {1'b0, code_shift_i[14:12]}; // Pad top nibble
         nibble_next[2] = code_shift_i[11:8];
         nibble_next[1] = code_shift_i[7:4];
         nibble_next[0] = code_shift_i[3:0];
      end else begin
         nibble_next[3] = value_word[15:12];
         nibble_next[2] = value_word[11:8];
         nibble_next[1] = value_word[7:4];
         nibble_next[0] = value_word[3:0];
      end
   end

   always_ff @(posedge clk_16_8) begin
      if (reset_i) begin
         ledr_o     <= '0;
         ledg_o     <= '0;
         digit_on_o <= '0; // All digits blank
      end else begin
         ledr_o     <= ledr_next;
         ledg_o     <= ledg_next;
         digit_on_o <= on_next;
      end
   end

   always_ff @(posedge clk_16_8) begin
      digit_nibble_o <= nibble_next; // Digit values
   end

endmodule

/* verilog/seg7_bank.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module seg7_bank
   import gps_board_pkg::*;
(
   input  nibble_t [`NUM_DIGITS-1:0] digit_nibble_i,
   input  logic [`NUM_DIGITS-1:0]    digit_on_i,
   output seg7_t                     hex0_o,
   output seg7_t                     hex1_o,
   output seg7_t                     hex2_o,
   output seg7_t                     hex3_o,
   output seg7_t                     hex4_o,
   output seg7_t                     hex5_o,
   output seg7_t                     hex6_o,
   output seg7_t                     hex7_o
);

   seg7_t [`NUM_DIGITS-1:0] seg;

   // Active-low pattern, bit 6 is g and bit 0 is a
   function automatic seg7_t hex_to_seg(input nibble_t nib);
      seg7_t pat;
      case (nib)
         4'h0:    pat = 7'h40;
         4'h1:    pat = 7'h79;
         4'h2:    pat = 7'h24;
         4'h3:    pat = 7'h30;
         4'h4:    pat = 7'h19;
         4'h5:    pat = 7'h12;
         4'h6:    pat = 7'h02;
         4'h7:    pat = 7'h78;
         4'h8:    pat = 7'h00;
         4'h9:    pat = 7'h10;
         4'ha:    pat = 7'h08;
         4'hb:    pat = 7'h03; // Lower case b
         4'hc:    pat = 7'h46;
         4'hd:    pat = 7'h21; // Lower case d
         4'he:    pat = 7'h06;
         default: pat = 7'h0e; // F
      endcase
      return pat;
   endfunction

   always_comb begin
      for (int d = 0; d < `NUM_DIGITS; d++) begin
         seg[d] = digit_on_i[d] ? hex_to_seg(digit_nibble_i[d]) : '1; // Blank is all high
      end
   end

   assign hex0_o = seg[0];
   assign hex1_o = seg[1];
   assign hex2_o = seg[2];
   assign hex3_o = seg[3];
   assign hex4_o = seg[4];
   assign hex5_o = seg[5];
   assign hex6_o = seg[6];
   assign hex7_o = seg[7];

endmodule

/* verilog/gps_board_top.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module gps_board_top
   import gps_board_pkg::*;
(
   input  logic                      clk_16_8,
   input  logic                      reset_i,
   input  logic [`SW_W-1:0]          sw_i,
   input  logic                      tracking_ready_i,
   input  iq_word_t                  i_prompt_i,
   input  iq_word_t                  q_prompt_i,
   input  acc_word_t                 acc_i_i,
   input  acc_word_t                 acc_q_i,
   input  code_shift_t               code_shift_i,
   input  feed_count_t               words_avail_i,
   input  feed_count_t               pkt_count_i,
   input  feed_count_t               good_pkt_count_i,
   input  logic [`TRACK_COUNT_W-1:0] track_count_i,
   input  logic [`SAMPLE_W-1:0]      carrier_i_i,
   input  logic [`SAMPLE_W-1:0]      carrier_q_i,
   input  logic [`SAMPLE_W-1:0]      sample_data_i,
   input  logic                      sample_valid_i,
   input  logic                      link_status_i,
   output logic                      sample_clk_o,
   output logic                      ready_flag_o,
   output ledr_t                     ledr_o,
   output ledg_t                     ledg_o,
   output seg7_t                     hex0_o,
   output seg7_t                     hex1_o,
   output seg7_t                     hex2_o,
   output seg7_t                     hex3_o,
   output seg7_t                     hex4_o,
   output seg7_t                     hex5_o,
   output seg7_t                     hex6_o,
   output seg7_t                     hex7_o
);

   nibble_t [`NUM_DIGITS-1:0] digit_nibble;
   logic [`NUM_DIGITS-1:0]    digit_on;

   sample_clock_gen u_sample_clock_gen (
      .clk_16_8     (clk_16_8),
      .reset_i      (reset_i),
      .sample_clk_o (sample_clk_o)
   );

   ready_stretcher u_ready_stretcher (
      .clk_16_8         (clk_16_8),
      .reset_i          (reset_i),
      .tracking_ready_i (tracking_ready_i),
      .ready_flag_o     (ready_flag_o)
   );

   status_display_mux u_status_display_mux (
      .clk_16_8         (clk_16_8),
      .reset_i          (reset_i),
      .sw_i             (sw_i),
      .ready_flag_i     (ready_flag_o), // Also shown on LEDG[0]
      .i_prompt_i       (i_prompt_i),
      .q_prompt_i       (q_prompt_i),
      .acc_i_i          (acc_i_i),
      .acc_q_i          (acc_q_i),
      .code_shift_i     (code_shift_i),
      .words_avail_i    (words_avail_i),
      .pkt_count_i      (pkt_count_i),
      .good_pkt_count_i (good_pkt_count_i),
      .track_count_i    (track_count_i),
      .carrier_i_i      (carrier_i_i),
      .carrier_q_i      (carrier_q_i),
      .sample_data_i    (sample_data_i),
      .sample_valid_i   (sample_valid_i),
      .link_status_i    (link_status_i),
      .ledr_o           (ledr_o),
      .ledg_o           (ledg_o),
      .digit_nibble_o   (digit_nibble),
      .digit_on_o       (digit_on)
   );

   seg7_bank u_seg7_bank (
      .digit_nibble_i (digit_nibble),
      .digit_on_i     (digit_on),
      .hex0_o         (hex0_o),
      .hex1_o         (hex1_o),
      .hex2_o         (hex2_o),
      .hex3_o         (hex3_o),
      .hex4_o         (hex4_o),
      .hex5_o         (hex5_o),
      .hex6_o         (hex6_o),
      .hex7_o         (hex7_o)
   );

endmodule

/* dv/gps_board_assert.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module gps_board_assert (
   input logic clk_16_8,
   input logic reset_i,
   input logic pulse_i,
   input logic flag_i,
   input logic slow_clk_i
);

   // Last pulse lies one hold plus two samples before the fall
   a_flag_hold: assert property (
      @(posedge clk_16_8) disable iff (reset_i)
         $fell(flag_i) |-> $past(pulse_i, `READY_HOLD + 2)
   ) else $error("ready flag fell without a full hold time");

   // Sample clock holds at least one cycle after each toggle
   a_slow_clk_hold: assert property (
      @(posedge clk_16_8) disable iff (reset_i) $changed(slow_clk_i) |=> $stable(slow_clk_i)
   ) else $error("sample clock toggled on consecutive cycles");

endmodule

/* dv/tb_gps_board.sv */
`timescale 1ns/10ps
`include "gps_board_defs.svh"

module tb_gps_board
   import gps_board_pkg::*;
();

   typedef struct {
      int                      due; // Cycle on which the outputs must match
      ledr_t                   ledr;
      ledg_t                   ledg;
      seg7_t [`NUM_DIGITS-1:0] hex;
   } expect_t;

   logic                      clk_16_8;
   logic                      reset_i;
   logic [`SW_W-1:0]          sw_i;
   logic                      tracking_ready_i;
   iq_word_t                  i_prompt_i;
   iq_word_t                  q_prompt_i;
   acc_word_t                 acc_i_i;
   acc_word_t                 acc_q_i;
   code_shift_t               code_shift_i;
   feed_count_t               words_avail_i;
   feed_count_t               pkt_count_i;
   feed_count_t               good_pkt_count_i;
   logic [`TRACK_COUNT_W-1:0] track_count_i;
   logic [`SAMPLE_W-1:0]      carrier_i_i;
   logic [`SAMPLE_W-1:0]      carrier_q_i;
   logic [`SAMPLE_W-1:0]      sample_data_i;
   logic                      sample_valid_i;
   logic                      link_status_i;
   logic                      sample_clk_o;
   logic                      ready_flag_o;
   ledr_t                     ledr_o;
   ledg_t                     ledg_o;
   seg7_t [`NUM_DIGITS-1:0]   hex;

   expect_t     exp_q[$];
   int          cycle_count = 0;
   int          since_reset = 0;
   int          since_pulse = 1000; // No pulse seen yet
   bit          exp_ready = 1'b0;
   logic [15:0] lfsr_state = 16'd21;
   int          src_hits[5];

   gps_board_top u_gps_board_top (
      .*,
      .hex0_o (hex[0]),
      .hex1_o (hex[1]),
      .hex2_o (hex[2]),
      .hex3_o (hex[3]),
      .hex4_o (hex[4]),
      .hex5_o (hex[5]),
      .hex6_o (hex[6]),
      .hex7_o (hex[7])
   );

   bind ready_stretcher gps_board_assert u_stretch_assert (
      .clk_16_8   (clk_16_8),
      .reset_i    (reset_i),
      .pulse_i    (tracking_ready_i),
      .flag_i     (ready_flag_o),
      .slow_clk_i (1'b0)
   );

   bind sample_clock_gen gps_board_assert u_divider_assert (
      .clk_16_8   (clk_16_8),
      .reset_i    (reset_i),
      .pulse_i    (1'b0),
      .flag_i     (1'b0),
      .slow_clk_i (sample_clk_o)
   );

   initial begin
      clk_16_8 = 1'b0;
      forever #20 clk_16_8 = ~clk_16_8;
   end

   always @(posedge clk_16_8) cycle_count <= cycle_count + 1;

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = lfsr_step(lfsr_state);
         val        = {val[30:0], lfsr_state[0]}; // One step per bit
      end
   endtask

   function automatic disp_src_e select_source(input logic [`SW_W-1:0] sw);
      if (sw[`SW_WORDS]) return DISP_FEED_WORDS;
      if (sw[`SW_TRACK]) return DISP_TRACK_COUNT;
      if (sw[`SW_PKT]) return sw[`SW_PKT_GOOD] ? DISP_PKT_GOOD : DISP_PKT_ALL;
      return DISP_IQ;
   endfunction

   function automatic iq_word_t value_word_of(input logic [`SW_W-1:0] sw, input iq_word_t i_p,
                                              input iq_word_t q_p, input acc_word_t a_i,
                                              input acc_word_t a_q);
      if (sw[`SW_ACC]) return sw[`SW_QSEL] ? a_q[`ACC_TRACK_W-1:0] : a_i[`ACC_TRACK_W-1:0];
      return sw[`SW_QSEL] ? q_p : i_p;
   endfunction

   function automatic ledr_t red_leds(input disp_src_e src, input iq_word_t value);
      case (src)
         DISP_FEED_WORDS:  return ledr_t'(words_avail_i);
         DISP_TRACK_COUNT: return ledr_t'(track_count_i);
         DISP_PKT_ALL:     return ledr_t'(pkt_count_i);
         DISP_PKT_GOOD:    return ledr_t'(good_pkt_count_i);
         default:          return ledr_t'(value);
      endcase
   endfunction

   function automatic ledg_t green_leds(input logic [`SW_W-1:0] sw, input bit ready);
      logic [`SAMPLE_W-1:0] carrier;
      carrier = sw[`SW_CARRIER_Q] ? carrier_q_i : carrier_i_i;
      return {link_status_i, carrier, sample_data_i, sample_valid_i, ready};
   endfunction

   // Lit segments gfedcba, the board wants them inverted
   function automatic seg7_t seg_pattern(input nibble_t nib);
      logic [6:0] lit;
      case (nib)
         4'h0:    lit = 7'b0111111;
         4'h1:    lit = 7'b0000110;
         4'h2:    lit = 7'b1011011;
         4'h3:    lit = 7'b1001111;
         4'h4:    lit = 7'b1100110;
         4'h5:    lit = 7'b1101101;
         4'h6:    lit = 7'b1111101;
         4'h7:    lit = 7'b0000111;
         4'h8:    lit = 7'b1111111;
         4'h9:    lit = 7'b1101111;
         4'ha:    lit = 7'b1110111;
         4'hb:    lit = 7'b1111100;
         4'hc:    lit = 7'b0111001;
         4'hd:    lit = 7'b1011110;
         4'he:    lit = 7'b1111001;
         default: lit = 7'b1110001;
      endcase
      return ~lit;
   endfunction

   function automatic seg7_t digit_segments(input int d, input logic [`SW_W-1:0] sw,
                                            input iq_word_t value, input code_shift_t cs);
      nibble_t nib;
      bit      lit_on;
      nib    = '0;
      lit_on = (d <= 4);
      case (d)
         0, 1, 2: nib = sw[`SW_CS] ? cs[d*4 +: 4] : value[d*4 +: 4];
         3:       nib = sw[`SW_CS] ? {1'b0, cs[14:12]} : value[15:12];
         4: begin
            nib    = {2'b00, value[17:16]};
            lit_on = !sw[`SW_CS]; // Code shift fits in four digits
         end
         default: lit_on = 1'b0;
      endcase
      return lit_on ? seg_pattern(nib) : 7'b1111111;
   endfunction

   task automatic stop_on_error();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_ledr(input ledr_t got, input ledr_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_ledg(input ledg_t got, input ledg_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_seg(input seg7_t got, input seg7_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_level(input bit got, input bit exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s expected %0b got %0b", $time, what, exp, got);
         stop_on_error();
      end
   endtask

   // Display outputs registered at the next edge
   task automatic queue_expected();
      expect_t  e;
      iq_word_t value;
      value  = value_word_of(sw_i, i_prompt_i, q_prompt_i, acc_i_i, acc_q_i);
      e.due  = cycle_count + 1;
      e.ledr = red_leds(select_source(sw_i), value);
      e.ledg = green_leds(sw_i, exp_ready);
      for (int d = 0; d < `NUM_DIGITS; d++) begin
         e.hex[d] = digit_segments(d, sw_i, value, code_shift_i);
      end
      exp_q.push_back(e);
   endtask

   // Steps to the next falling edge and checks both level outputs
   task automatic next_cycle();
      @(negedge clk_16_8);
      since_reset++;
      since_pulse = tracking_ready_i ? 1 : since_pulse + 1;
      exp_ready   = (since_pulse >= 1) && (since_pulse <= `READY_HOLD + 1);
      check_level(sample_clk_o, ((since_reset / (`SAMPLE_DIV_RELOAD + 1)) % 2) == 1,
                  "sample clock");
      check_level(ready_flag_o, exp_ready, "ready flag");
   endtask

   task automatic pulse_ready(input int second_at, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         next_cycle();
         tracking_ready_i = (c == 0) || (c == second_at);
         queue_expected();
      end
   endtask

   task automatic wait_flag_low(input int limit);
      int n;
      n = 0;
      while (ready_flag_o !== 1'b0 && n < limit) begin
         next_cycle();
         queue_expected();
         n++;
      end
      if (ready_flag_o !== 1'b0) begin
         $display("ERROR: ready flag still high after %0d cycles", limit);
         stop_on_error();
      end
   endtask

   task automatic wait_checks_done(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         next_cycle();
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("ERROR: %0d display checks never came due", exp_q.size());
         stop_on_error();
      end
   endtask

   task automatic drive_random();
      logic [31:0] r;
      next_cycle();
      rand_bits(`SW_W, r);
      sw_i = r[`SW_W-1:0];
      rand_bits(`ACC_TRACK_W, r);
      i_prompt_i = r[`ACC_TRACK_W-1:0];
      rand_bits(`ACC_TRACK_W, r);
      q_prompt_i = r[`ACC_TRACK_W-1:0];
      rand_bits(`ACC_W, r);
      acc_i_i = r[`ACC_W-1:0];
      rand_bits(`ACC_W, r);
      acc_q_i = r[`ACC_W-1:0];
      rand_bits(`CODE_SHIFT_W, r);
      code_shift_i = r[`CODE_SHIFT_W-1:0];
      rand_bits(3 * `FEED_COUNT_W, r);
      {words_avail_i, pkt_count_i, good_pkt_count_i} = r[3*`FEED_COUNT_W-1:0];
      rand_bits(`TRACK_COUNT_W + 3 * `SAMPLE_W + 2, r);
      {track_count_i, carrier_i_i, carrier_q_i, sample_data_i, sample_valid_i,
       link_status_i} = r[`TRACK_COUNT_W+3*`SAMPLE_W+1:0];
      src_hits[int'(select_source(sw_i))]++;
      queue_expected();
   endtask

   always @(negedge clk_16_8) begin : compare_outputs
      expect_t e;
      if (exp_q.size() > 0 && exp_q[0].due == cycle_count) begin
         e = exp_q.pop_front();
         check_ledr(ledr_o, e.ledr, "LEDR");
         check_ledg(ledg_o, e.ledg, "LEDG");
         for (int d = 0; d < `NUM_DIGITS; d++) begin
            check_seg(hex[d], e.hex[d], $sformatf("HEX%0d", d));
         end
      end
   end

   initial begin : stimulus
      bit cov_ok;
      reset_i          = 1'b1;
      sw_i             = '0;
      tracking_ready_i = 1'b0;
      i_prompt_i       = '0;
      q_prompt_i       = '0;
      acc_i_i          = '0;
      acc_q_i          = '0;
      code_shift_i     = '0;
      words_avail_i    = '0;
      pkt_count_i      = '0;
      good_pkt_count_i = '0;
      track_count_i    = '0;
      carrier_i_i      = '0;
      carrier_q_i      = '0;
      sample_data_i    = '0;
      sample_valid_i   = 1'b0;
      link_status_i    = 1'b0;
      for (int s = 0; s < 5; s++) src_hits[s] = 0;

      repeat (5) @(negedge clk_16_8);
      check_level(sample_clk_o, 1'b0, "sample clock in reset");
      check_level(ready_flag_o, 1'b0, "ready flag in reset");
      check_ledr(ledr_o, '0, "LEDR in reset");
      check_ledg(ledg_o, '0, "LEDG in reset");
      for (int d = 0; d < `NUM_DIGITS; d++) begin
         check_seg(hex[d], 7'b1111111, $sformatf("HEX%0d in reset", d));
      end
      reset_i = 1'b0;

      repeat (10 * 2 * (`SAMPLE_DIV_RELOAD + 1) + 4) begin // Ten sample periods
         next_cycle();
         queue_expected();
      end
      pulse_ready(-1, 12); // Single pulse
      pulse_ready(4, 16);  // Second pulse inside the hold
      wait_flag_low(20);
      repeat (240) drive_random();
      wait_checks_done(4);

      cov_ok = 1'b1;
      for (int s = 0; s < 5; s++) begin
         if (src_hits[s] == 0) begin
            $display("ERROR: red LED source %0d was never selected", s);
            cov_ok = 1'b0;
         end
      end
      if (cov_ok) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_on_error();
      end
   end

endmodule

/* gps_board_top.f */
+incdir+verilog
verilog/gps_board_pkg.sv
verilog/sample_clock_gen.sv
verilog/ready_stretcher.sv
verilog/status_display_mux.sv
verilog/seg7_bank.sv
verilog/gps_board_top.sv
dv/gps_board_assert.sv
dv/tb_gps_board.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gps_board
FILELIST  ?= gps_board_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
